// File: hw/data_port.sv
// data bus responder
// decodes RAM, peripheral and unmapped space and returns the response
`timescale 1ns/100ps
`include "mm_ram_consts.svh"

module data_port import mm_ram_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    data_req_i,
    input  addr_t   data_addr_i,
    input  logic    data_we_i,
    input  be_t     data_be_i,
    input  word_t   data_wdata_i,
    output logic    data_gnt_o,
    output logic    data_rvalid_o,
    output word_t   data_rdata_o,
    ram_port_if.req ram,
    output logic    periph_we_o,
    output addr_t   periph_addr_o,
    output word_t   periph_wdata_o
);

    logic is_ram;
    logic is_periph;
    logic rvalid_q;
    logic ram_rd_q;

    // region decode
    assign is_ram    = (data_addr_i[31:`MM_RAM_ADDR_WIDTH] == '0);
    assign is_periph = (data_addr_i == `MM_STATUS_ADDR) ||
                       (data_addr_i == `MM_EXIT_ADDR)   ||
                       (data_addr_i == `MM_TIMER_ADDR);

    // every request is taken in the cycle it appears
    assign data_gnt_o = data_req_i;

    // RAM side
    assign ram.en    = data_req_i && is_ram;
    assign ram.we    = data_we_i;
    assign ram.be    = data_be_i;
    assign ram.idx   = data_addr_i[`MM_RAM_ADDR_WIDTH-1:2];
    assign ram.wdata = data_wdata_i;

    // peripheral side only sees writes, reads there return zero
    assign periph_we_o    = data_req_i && data_we_i && is_periph;
    assign periph_addr_o  = data_addr_i;
    assign periph_wdata_o = data_wdata_i;

    // remember whether the response carries RAM read data
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
            ram_rd_q <= 1'b0;
        end else begin
            rvalid_q <= data_req_i;
            ram_rd_q <= data_req_i && is_ram && !data_we_i;
        end
    end

    assign data_rvalid_o = rvalid_q;
    // writes, peripheral reads and unmapped reads answer with zero
    assign data_rdata_o  = ram_rd_q ? ram.rdata : '0;

    a_write_has_bytes: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (data_req_i && data_we_i) |-> (data_be_i != '0)
    ) else $error("data_port: write with no byte enables at %h", data_addr_i);

endmodule

// File: hw/dp_ram.sv
// dual-port byte-writable RAM
// read-first on both ports, read data registered
`timescale 1ns/100ps
`include "mm_ram_consts.svh"

module dp_ram import mm_ram_pkg::*; (
    input logic     clk_i,
    ram_port_if.mem port_a,
    ram_port_if.mem port_b
);

    word_t mem [`MM_RAM_WORDS];

    // both ports share one process so the array has a single driver
    // port b is written last and wins a same-word collision
    always_ff @(posedge clk_i) begin
        if (port_a.en) begin
            if (port_a.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (port_a.be[i]) begin
                        mem[port_a.idx][8*i +: 8] <= port_a.wdata[8*i +: 8];
                    end
                end
            end
            // nonblocking read sees the word before this edge's writes
            port_a.rdata <= mem[port_a.idx];
        end
        if (port_b.en) begin
            if (port_b.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (port_b.be[i]) begin
                        mem[port_b.idx][8*i +: 8] <= port_b.wdata[8*i +: 8];
                    end
                end
            end
            port_b.rdata <= mem[port_b.idx];
        end
    end

    // the two bus sides must never write the same word together
    a_no_write_collision: assert property (
        @(posedge clk_i)
        !(port_a.en && port_a.we && port_b.en && port_b.we &&
          (port_a.idx == port_b.idx))
    ) else $error("dp_ram: both ports write word %0d", port_a.idx);

endmodule

// File: hw/instr_port.sv
// instruction fetch responder
// grants every fetch, reads the RAM and answers one cycle later
`timescale 1ns/100ps
`include "mm_ram_consts.svh"

module instr_port import mm_ram_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    instr_req_i,
    input  addr_t   instr_addr_i,
    output logic    instr_gnt_o,
    output logic    instr_rvalid_o,
    output word_t   instr_rdata_o,
    ram_port_if.req ram
);

    logic in_range;
    logic rvalid_q;
    logic in_range_q;

    // address lies inside the RAM when the upper bits are clear
    assign in_range = (instr_addr_i[31:`MM_RAM_ADDR_WIDTH] == '0);

    // no wait states on the fetch side
    assign instr_gnt_o = instr_req_i;

    // read-only use of the RAM port
    assign ram.en    = instr_req_i && in_range;
    assign ram.we    = 1'b0;
    assign ram.be    = '0;
    assign ram.idx   = instr_addr_i[`MM_RAM_ADDR_WIDTH-1:2];
    assign ram.wdata = '0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q   <= 1'b0;
            in_range_q <= 1'b0;
        end else begin
            rvalid_q   <= instr_req_i;
            in_range_q <= instr_req_i && in_range;
        end
    end

    assign instr_rvalid_o = rvalid_q;
    // out-of-range fetches read back as zero
    assign instr_rdata_o  = in_range_q ? ram.rdata : '0;

    // the RAM index drops the byte offset, so fetches must be word aligned
    a_fetch_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        instr_req_i |-> (instr_addr_i[1:0] == 2'b00)
    ) else $error("instr_port: misaligned fetch at %h", instr_addr_i);

endmodule

// File: hw/mm_ram_consts.svh
// memory subsystem constants
// RAM size and the pseudo-peripheral address map
`ifndef MM_RAM_CONSTS_SVH
`define MM_RAM_CONSTS_SVH

// byte address width of the shared RAM, 64 KiB
`define MM_RAM_ADDR_WIDTH 16

// number of 32-bit words in the RAM
`define MM_RAM_WORDS (1 << (`MM_RAM_ADDR_WIDTH - 2))

// test-status register, a write of the pass magic sets pass
`define MM_STATUS_ADDR 32'h2000_0000

// exit register, a write pulses exit valid
`define MM_EXIT_ADDR 32'h2000_0004

// timer compare register
`define MM_TIMER_ADDR 32'h1500_0000

// status value that signals a passing test
`define MM_PASS_MAGIC 32'd123456789

`endif

// File: hw/mm_ram_pkg.sv
// memory subsystem types
// vector typedefs shared by the RTL blocks and the testbench
`include "mm_ram_consts.svh"

package mm_ram_pkg;

    // one bus data word
    typedef logic [31:0] word_t;

    // bus byte address
    typedef logic [31:0] addr_t;

    // byte enables, one per byte lane of word_t
    typedef logic [3:0] be_t;

    // word index into the RAM array, byte offset dropped
    typedef logic [`MM_RAM_ADDR_WIDTH-3:0] ram_idx_t;

endpackage

// File: hw/mm_subsystem.sv
// memory subsystem top level
// shared RAM behind fetch and data ports, plus simulation peripherals
`timescale 1ns/100ps

module mm_subsystem import mm_ram_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,

    // instruction bus
    input  logic  instr_req_i,
    input  addr_t instr_addr_i,
    output logic  instr_gnt_o,
    output logic  instr_rvalid_o,
    output word_t instr_rdata_o,

    // data bus
    input  logic  data_req_i,
    input  addr_t data_addr_i,
    input  logic  data_we_i,
    input  be_t   data_be_i,
    input  word_t data_wdata_i,
    output logic  data_gnt_o,
    output logic  data_rvalid_o,
    output word_t data_rdata_o,

    // test status and interrupt
    output logic  tests_passed_o,
    output logic  tests_failed_o,
    output logic  exit_valid_o,
    output word_t exit_value_o,
    output logic  irq_timer_o
);

    logic  periph_we;
    addr_t periph_addr;
    word_t periph_wdata;

    ram_port_if instr_ram ();
    ram_port_if data_ram ();

    instr_port u_instr_port (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .ram            (instr_ram)
    );

    data_port u_data_port (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .ram            (data_ram),
        .periph_we_o    (periph_we),
        .periph_addr_o  (periph_addr),
        .periph_wdata_o (periph_wdata)
    );

    // port a serves fetches, port b the data bus
    dp_ram u_dp_ram (
        .clk_i  (clk_i),
        .port_a (instr_ram),
        .port_b (data_ram)
    );

    sim_periph u_sim_periph (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .periph_we_i    (periph_we),
        .periph_addr_i  (periph_addr),
        .periph_wdata_i (periph_wdata),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .irq_timer_o    (irq_timer_o)
    );

endmodule

// File: hw/ram_port_if.sv
// one access port of the shared RAM
// requester drives the access, memory returns registered read data
`timescale 1ns/100ps

interface ram_port_if import mm_ram_pkg::*; ();

    logic     en;
    logic     we;
    be_t      be;
    ram_idx_t idx;
    word_t    wdata;
    word_t    rdata;

    // held by the port responders
    modport req (
        output en, we, be, idx, wdata,
        input  rdata
    );

    // held by the RAM
    modport mem (
        input  en, we, be, idx, wdata,
        output rdata
    );

endinterface

// File: hw/sim_periph.sv
// simulation pseudo-peripherals
// test status flags, exit register and a compare timer with interrupt
`timescale 1ns/100ps
`include "mm_ram_consts.svh"

module sim_periph import mm_ram_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  periph_we_i,
    input  addr_t periph_addr_i,
    input  word_t periph_wdata_i,
    output logic  tests_passed_o,
    output logic  tests_failed_o,
    output logic  exit_valid_o,
    output word_t exit_value_o,
    output logic  irq_timer_o
);

    logic  status_we;
    logic  exit_we;
    logic  timer_we;
    logic  passed_q;
    logic  failed_q;
    logic  exit_valid_q;
    word_t exit_value_q;
    word_t timer_cmp_q;
    word_t timer_cnt_q;
    logic  irq_q;

    assign status_we = periph_we_i && (periph_addr_i == `MM_STATUS_ADDR);
    assign exit_we   = periph_we_i && (periph_addr_i == `MM_EXIT_ADDR);
    assign timer_we  = periph_we_i && (periph_addr_i == `MM_TIMER_ADDR);

    // each status write sets its flag, both stay set until reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            passed_q <= 1'b0;
            failed_q <= 1'b0;
        end else if (status_we) begin
            if (periph_wdata_i == `MM_PASS_MAGIC) begin
                passed_q <= 1'b1;
            end else begin
                failed_q <= 1'b1;
            end
        end
    end

    // exit strobe lasts one cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exit_valid_q <= 1'b0;
        end else begin
            exit_valid_q <= exit_we;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exit_we) begin
            exit_value_q <= periph_wdata_i;
        end
    end

    // counter stops once the interrupt is up, compare of zero disables
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            timer_cmp_q <= '0;
            timer_cnt_q <= '0;
            irq_q       <= 1'b0;
        end else if (timer_we) begin
            timer_cmp_q <= periph_wdata_i;
            timer_cnt_q <= '0;
            irq_q       <= 1'b0;
        end else if ((timer_cmp_q != '0) && !irq_q) begin
            timer_cnt_q <= timer_cnt_q + 32'd1;
            if (timer_cnt_q + 32'd1 == timer_cmp_q) begin
                irq_q <= 1'b1;
            end
        end
    end

    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;
    assign irq_timer_o    = irq_q;

    a_single_verdict: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(tests_passed_o && tests_failed_o)
    ) else $error("sim_periph: pass and fail both set");

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_mm_subsystem -Mdir obj_dir
out=$(./obj_dir/Vtb_mm_subsystem)
echo "$out"
echo "$out" | grep -qx "all tests passed"

// File: sim.f
+incdir+hw
hw/mm_ram_pkg.sv
hw/ram_port_if.sv
hw/dp_ram.sv
hw/instr_port.sv
hw/data_port.sv
hw/sim_periph.sv
hw/mm_subsystem.sv
tests/tb_mm_subsystem.sv

// File: tests/tb_mm_subsystem.sv
// testbench for the memory subsystem
// plays the core on both buses and checks responses against a reference model
`timescale 1ns/100ps
`include "mm_ram_consts.svh"

module tb_mm_subsystem import mm_ram_pkg::*; ();

    localparam int TEST_WORDS  = 64;
    localparam int DRAIN_LIMIT = 20;

    logic  clk;
    logic  reset;
    logic  instr_req;
    addr_t instr_addr;
    logic  instr_gnt;
    logic  instr_rvalid;
    word_t instr_rdata;
    logic  data_req;
    addr_t data_addr;
    logic  data_we;
    be_t   data_be;
    word_t data_wdata;
    logic  data_gnt;
    logic  data_rvalid;
    word_t data_rdata;
    logic  tests_passed;
    logic  tests_failed;
    logic  exit_valid;
    word_t exit_value;
    logic  irq_timer;

    word_t mem_model [ram_idx_t];
    word_t data_exp [$];
    word_t instr_exp [$];
    logic  data_req_q;
    logic  instr_req_q;
    int    n_value = 0;
    int    n_protocol = 0;
    int    n_timeout = 0;

    mm_subsystem u_mm_subsystem (
        .clk_i          (clk),
        .reset_i        (reset),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_addr_i    (data_addr),
        .data_we_i      (data_we),
        .data_be_i      (data_be),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value),
        .irq_timer_o    (irq_timer)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected read data, anything at or above the RAM size reads zero
    function automatic word_t ref_read(addr_t addr);
        ram_idx_t idx;
        idx = addr[`MM_RAM_ADDR_WIDTH-1:2];
        if (addr >= (32'd1 << `MM_RAM_ADDR_WIDTH) || !mem_model.exists(idx)) begin
            return '0;
        end
        return mem_model[idx];
    endfunction

    function automatic void model_write(addr_t addr, be_t be, word_t wdata);
        ram_idx_t idx;
        word_t    word;
        idx = addr[`MM_RAM_ADDR_WIDTH-1:2];
        if (addr < (32'd1 << `MM_RAM_ADDR_WIDTH)) begin
            word = ref_read(addr);
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    word[8*i +: 8] = wdata[8*i +: 8];
                end
            end
            mem_model[idx] = word;
        end
    endfunction

    function automatic addr_t word_addr();
        return addr_t'($urandom_range(0, TEST_WORDS - 1)) << 2;
    endfunction

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            n_value++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            n_value++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one bus cycle on both ports, expectations queued in issue order
    task automatic bus_cycle(logic ireq, addr_t iaddr, logic dreq, logic dwe,
                             addr_t daddr, be_t dbe, word_t dwdata);
        @(posedge clk);
        #1;
        instr_req  = ireq;
        instr_addr = iaddr;
        data_req   = dreq;
        data_we    = dwe;
        data_addr  = daddr;
        data_be    = dbe;
        data_wdata = dwdata;
        // the fetch is modelled first so it sees the word before a same-cycle write
        if (ireq) begin
            instr_exp.push_back(ref_read(iaddr));
        end
        if (dreq && dwe) begin
            data_exp.push_back('0);
            model_write(daddr, dbe, dwdata);
        end else if (dreq) begin
            data_exp.push_back(ref_read(daddr));
        end
    endtask

    task automatic idle();
        bus_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while ((data_exp.size() != 0 || instr_exp.size() != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (data_exp.size() != 0 || instr_exp.size() != 0) begin
            n_timeout++;
            $display("timeout: %0d data and %0d fetch responses never arrived",
                     data_exp.size(), instr_exp.size());
            data_exp.delete();
            instr_exp.delete();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // responses are sampled mid-cycle where they are stable
    always @(negedge clk) begin
        if (reset) begin
            data_req_q  = 1'b0;
            instr_req_q = 1'b0;
        end else begin
            check_bit("data gnt", data_gnt, data_req);
            check_bit("instr gnt", instr_gnt, instr_req);
            check_bit("data rvalid", data_rvalid, data_req_q);
            check_bit("instr rvalid", instr_rvalid, instr_req_q);
            if (data_rvalid && data_exp.size() == 0) begin
                n_protocol++;
                $display("data response at %0t with no request outstanding", $time);
            end else if (data_rvalid) begin
                check_word("data rdata", data_rdata, data_exp.pop_front());
            end
            if (instr_rvalid && instr_exp.size() == 0) begin
                n_protocol++;
                $display("fetch response at %0t with no request outstanding", $time);
            end else if (instr_rvalid) begin
                check_word("instr rdata", instr_rdata, instr_exp.pop_front());
            end
            data_req_q  = data_req;
            instr_req_q = instr_req;
        end
    end

    initial begin
        addr_t addr;
        word_t value;
        int    n_cmp;
        void'($urandom(10));
        reset      = 1'b1;
        instr_req  = 1'b0;
        instr_addr = '0;
        data_req   = 1'b0;
        data_addr  = '0;
        data_we    = 1'b0;
        data_be    = '0;
        data_wdata = '0;
        apply_reset();
        @(negedge clk);
        check_bit("tests_passed after reset", tests_passed, 1'b0);
        check_bit("tests_failed after reset", tests_failed, 1'b0);
        check_bit("exit_valid after reset", exit_valid, 1'b0);
        check_bit("irq_timer after reset", irq_timer, 1'b0);

        // fill the test window, then mix random traffic on both ports
        for (int i = 0; i < TEST_WORDS; i++) begin
            bus_cycle(1'b0, '0, 1'b1, 1'b1, addr_t'(4 * i), 4'hf, $urandom());
        end
        for (int i = 0; i < 300; i++) begin
            addr = word_addr();
            bus_cycle($urandom_range(0, 1) == 1, word_addr(), $urandom_range(0, 3) != 0,
                      $urandom_range(0, 1) == 1, addr, be_t'($urandom_range(1, 15)),
                      $urandom());
        end
        for (int i = 0; i < TEST_WORDS; i++) begin
            bus_cycle(1'b1, addr_t'(4 * i), 1'b1, 1'b0,
                      addr_t'(4 * (TEST_WORDS - 1 - i)), '0, '0);
        end

        // fetch and write hitting the same word in one cycle
        for (int i = 0; i < 8; i++) begin
            addr = word_addr();
            bus_cycle(1'b1, addr, 1'b1, 1'b1, addr, 4'hf, $urandom());
            bus_cycle(1'b1, addr, 1'b1, 1'b0, addr, '0, '0);
        end

        // out of range and unmapped accesses
        bus_cycle(1'b1, 32'h0001_0000, 1'b1, 1'b0, `MM_STATUS_ADDR, '0, '0);
        bus_cycle(1'b1, 32'h8000_0040, 1'b1, 1'b0, 32'h3000_0000, '0, '0);
        addr = word_addr();
        bus_cycle(1'b0, '0, 1'b1, 1'b1, addr | 32'h0004_0000, 4'hf, 32'hdead_beef);
        bus_cycle(1'b1, addr, 1'b1, 1'b0, addr, '0, '0);
        idle();
        drain();

        // timer compare, irq rises on the N-th edge after acceptance
        n_cmp = $urandom_range(3, 40);
        bus_cycle(1'b0, '0, 1'b1, 1'b1, `MM_TIMER_ADDR, 4'hf, n_cmp);
        idle();
        for (int k = 0; k <= n_cmp + 2; k++) begin
            @(negedge clk);
            check_bit("irq_timer", irq_timer, k >= n_cmp);
        end
        bus_cycle(1'b0, '0, 1'b1, 1'b1, `MM_TIMER_ADDR, 4'hf, 32'd1000);
        idle();
        @(negedge clk);
        check_bit("irq_timer after compare write", irq_timer, 1'b0);

        // exit pulse, then a passing status write
        value = $urandom();
        bus_cycle(1'b0, '0, 1'b1, 1'b1, `MM_EXIT_ADDR, 4'hf, value);
        idle();
        @(negedge clk);
        check_bit("exit_valid", exit_valid, 1'b1);
        check_word("exit_value", exit_value, value);
        @(negedge clk);
        check_bit("exit_valid second cycle", exit_valid, 1'b0);
        check_word("exit_value held", exit_value, value);
        bus_cycle(1'b0, '0, 1'b1, 1'b1, `MM_STATUS_ADDR, 4'hf, `MM_PASS_MAGIC);
        idle();
        @(negedge clk);
        check_bit("tests_passed", tests_passed, 1'b1);
        check_bit("tests_failed", tests_failed, 1'b0);
        drain();

        // any other status value after a reset means fail
        apply_reset();
        @(negedge clk);
        check_bit("tests_passed after reset", tests_passed, 1'b0);
        check_bit("tests_failed after reset", tests_failed, 1'b0);
        value = $urandom();
        if (value == `MM_PASS_MAGIC) begin
            value = value + 32'd1;
        end
        bus_cycle(1'b0, '0, 1'b1, 1'b1, `MM_STATUS_ADDR, 4'hf, value);
        idle();
        @(negedge clk);
        check_bit("tests_failed", tests_failed, 1'b1);
        check_bit("tests_passed", tests_passed, 1'b0);
        drain();

        $display("errors: %0d value, %0d protocol, %0d timeout",
                 n_value, n_protocol, n_timeout);
        if (n_value + n_protocol + n_timeout == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
